//--- hdl/stream_buf_settings.svh
`ifndef STREAM_BUF_SETTINGS_SVH
`define STREAM_BUF_SETTINGS_SVH

// ----------------------------------------
// stream format
// ----------------------------------------
`define SAMPLE_BITS 8                                 // one sample.
`define PACK_DEPTH 4                                  // samples per memory word.
`define WORD_BITS (`SAMPLE_BITS * `PACK_DEPTH)

// ----------------------------------------
// memory geometry
// ----------------------------------------
`define ADDR_BITS 4                                   // 16 words.
`define MEM_DEPTH (1 << `ADDR_BITS)

// registers behind the array read, 2 for block RAM, 0 for distributed RAM.
// back-to-back streaming needs PACK_DEPTH >= MEM_OUT_STAGES + 2
`define MEM_OUT_STAGES 2

`endif

//--- hdl/stream_buf_pkg.sv
`include "stream_buf_settings.svh"

package stream_buf_pkg;

    typedef logic [`SAMPLE_BITS-1:0] sample_t;
    typedef logic [`WORD_BITS-1:0]   word_t;        // oldest sample in the top slice.
    typedef logic [`ADDR_BITS-1:0]   addr_t;
    typedef logic [`ADDR_BITS:0]     count_t;       // one extra bit to hold a full count.

    // ----------------------------------------
    // write request into the memory block
    // ----------------------------------------
    typedef struct packed {
        logic  strobe;
        addr_t addr;
        word_t data;
    } wr_req_t;

    // read side of the batch controller
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,                                    // memory read in flight.
        RD_STREAM                                   // unpacker emitting samples.
    } rd_state_t;

endpackage

//--- hdl/memory_block.sv
`timescale 1ns/1ps

module memory_block #(
    parameter int WIDTH      = 32,
    parameter int DEPTH_LOG2 = 4,
    parameter int OUT_STAGES = 2
) (
    input  logic                    clk,

    // write side
    input  stream_buf_pkg::wr_req_t wr,

    // read side
    input  logic                    rd_stall,
    input  stream_buf_pkg::addr_t   rd_addr,
    output stream_buf_pkg::word_t   rd_data
);
    import stream_buf_pkg::*;

    logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
    wr_req_t               wr_q;
    logic [DEPTH_LOG2-1:0] rd_addr_q;
    logic [WIDTH-1:0]      mem_out;

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        wr_q <= wr;                                 // request lands one cycle late.
        if (wr_q.strobe) begin
            mem[wr_q.addr] <= wr_q.data;
        end
    end

    // ----------------------------------------
    // read port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rd_stall) begin
            rd_addr_q <= rd_addr;
        end
    end

    assign mem_out = mem[rd_addr_q];

    generate
        if (OUT_STAGES == 0) begin : g_no_pipe
            assign rd_data = mem_out;
        end else begin : g_pipe
            logic [WIDTH-1:0] pipe [OUT_STAGES];

            always_ff @(posedge clk) begin
                pipe[0] <= mem_out;
                for (int i = 1; i < OUT_STAGES; i++) begin
                    pipe[i] <= pipe[i-1];
                end
            end

            assign rd_data = pipe[OUT_STAGES-1];     // oldest stage.
        end
    endgenerate

    // the controller frees a slot only after its read has left the address register,
    // so an issued read never meets a write to the same word.
    a_no_read_during_write: assert property (
        @(posedge clk)
        !rd_stall |=> !(wr_q.strobe && (rd_addr_q == wr_q.addr))
    ) else $error("memory_block: read of address %0d while it is written", rd_addr_q);

endmodule

//--- hdl/packing_shift_register.sv
`timescale 1ns/1ps

module packing_shift_register #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    shift_en,
    input  stream_buf_pkg::sample_t sample_in,
    output stream_buf_pkg::word_t   packed_out
);

    logic [WIDTH-1:0] stage [DEPTH];            // stage 0 holds the newest sample.

    always_ff @(posedge clk) begin
        if (shift_en) begin
            stage[0] <= sample_in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // oldest sample ends up in the top slice
    generate
        for (genvar i = 0; i < DEPTH; i++) begin : g_slice
            assign packed_out[i*WIDTH +: WIDTH] = stage[i];
        end
    endgenerate

endmodule

//--- hdl/unpacking_shift_register.sv
`timescale 1ns/1ps

module unpacking_shift_register #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    start_batch,
    input  stream_buf_pkg::word_t   packed_in,
    output stream_buf_pkg::sample_t sample_out
);

    // top slice leaves at once, the rest wait here. stage DEPTH-2 is next out.
    logic [WIDTH-1:0] stage [DEPTH-1];

    assign sample_out = start_batch ? packed_in[(DEPTH-1)*WIDTH +: WIDTH]
                                    : stage[DEPTH-2];

    always_ff @(posedge clk) begin
        if (start_batch) begin
            for (int i = 0; i < DEPTH-1; i++) begin
                stage[i] <= packed_in[i*WIDTH +: WIDTH];
            end
        end else begin
            // a new batch starts before this stage reaches the output.
            stage[0] <= {WIDTH{1'bx}};
            for (int i = 1; i < DEPTH-1; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

endmodule

//--- hdl/batch_controller.sv
`timescale 1ns/1ps

`include "stream_buf_settings.svh"

module batch_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    sample_valid,
    input  logic                    drain,
    input  stream_buf_pkg::word_t   packed_word,
    output stream_buf_pkg::wr_req_t wr,
    output logic                    rd_stall,
    output stream_buf_pkg::addr_t   rd_addr,
    output logic                    start_batch,
    output logic                    sample_out_valid,
    output logic                    overflow,
    output stream_buf_pkg::count_t  word_count
);
    import stream_buf_pkg::*;

    localparam int DEPTH     = `MEM_DEPTH;
    localparam int LAST      = `PACK_DEPTH - 1;
    localparam int CNT_BITS  = (`PACK_DEPTH > 1) ? $clog2(`PACK_DEPTH) : 1;
    localparam int WAIT_BITS = (`MEM_OUT_STAGES > 0) ? $clog2(`MEM_OUT_STAGES + 1) : 1;
    // stream slot for the next read, so its data lands right after the last sample
    localparam int ISSUE_AT  = `PACK_DEPTH - 2 - `MEM_OUT_STAGES;

    logic [CNT_BITS-1:0]  samp_cnt;
    logic                 pack_done;
    count_t               wr_ptr;
    count_t               rd_ptr;
    count_t               occupancy;
    logic                 full;
    logic                 commit_q;
    logic                 issue;
    rd_state_t            rd_state;
    logic [WAIT_BITS-1:0] wait_cnt;
    logic [CNT_BITS-1:0]  stream_cnt;
    logic                 next_pending;

    // ----------------------------------------
    // write side
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            samp_cnt  <= '0;
            pack_done <= 1'b0;
            wr_ptr    <= '0;
            commit_q  <= 1'b0;
        end else begin
            pack_done <= sample_valid && (samp_cnt == CNT_BITS'(LAST));
            if (sample_valid) begin
                samp_cnt <= (samp_cnt == CNT_BITS'(LAST)) ? '0 : samp_cnt + 1'b1;
            end
            if (wr.strobe) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            commit_q <= wr.strobe;              // stored one edge after this.
        end
    end

    // slot being read this cycle still counts as taken.
    assign occupancy = wr_ptr - rd_ptr;
    assign full      = (occupancy == count_t'(DEPTH)) ||
                       ((occupancy == count_t'(DEPTH - 1)) && !rd_stall);

    assign wr.strobe = pack_done && !full;
    assign wr.addr   = wr_ptr[`ADDR_BITS-1:0];
    assign wr.data   = packed_word;
    assign overflow  = pack_done && full;        // whole word dropped.

    // ----------------------------------------
    // read side
    // ----------------------------------------
    always_comb begin
        issue = 1'b0;
        if (drain && (word_count != '0)) begin
            if (rd_state == RD_IDLE) begin
                issue = 1'b1;
            end else if ((rd_state == RD_STREAM) && (stream_cnt == CNT_BITS'(ISSUE_AT))) begin
                issue = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state         <= RD_IDLE;
            rd_ptr           <= '0;
            rd_addr          <= '0;
            rd_stall         <= 1'b1;
            wait_cnt         <= '0;
            stream_cnt       <= '0;
            next_pending     <= 1'b0;
            start_batch      <= 1'b0;
            sample_out_valid <= 1'b0;
            word_count       <= '0;
        end else begin
            rd_stall    <= !issue;                  // address open for one cycle.
            start_batch <= 1'b0;
            word_count  <= word_count + count_t'(commit_q) - count_t'(issue);
            if (issue) begin
                rd_addr <= rd_ptr[`ADDR_BITS-1:0];
                rd_ptr  <= rd_ptr + 1'b1;
            end

            case (rd_state)
                RD_IDLE: begin
                    if (issue) begin
                        rd_state <= RD_WAIT;
                        wait_cnt <= WAIT_BITS'(`MEM_OUT_STAGES);
                    end
                end
                RD_WAIT: begin
                    if (wait_cnt == '0) begin
                        rd_state         <= RD_STREAM;
                        stream_cnt       <= '0;
                        start_batch      <= 1'b1;   // data arrives this edge.
                        sample_out_valid <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                RD_STREAM: begin
                    if (issue) begin
                        next_pending <= 1'b1;
                    end
                    if (stream_cnt == CNT_BITS'(LAST)) begin
                        stream_cnt <= '0;
                        if (next_pending) begin
                            start_batch  <= 1'b1;   // gapless follow-on word.
                            next_pending <= 1'b0;
                        end else begin
                            rd_state         <= RD_IDLE;
                            sample_out_valid <= 1'b0;
                        end
                    end else begin
                        stream_cnt <= stream_cnt + 1'b1;
                    end
                end
                default: begin
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        word_count <= count_t'(DEPTH)
    ) else $error("batch_controller: word_count %0d above depth", word_count);

    // read address opened MEM_OUT_STAGES + 1 cycles before its batch starts.
    a_batch_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        start_batch |-> (rd_state == RD_STREAM) &&
                        !$past(rd_stall, `MEM_OUT_STAGES + 1) &&
                        (($past(rd_state) == RD_WAIT) ||
                         (($past(rd_state) == RD_STREAM) &&
                          ($past(stream_cnt) == CNT_BITS'(LAST))))
    ) else $error("batch_controller: start_batch outside a batch boundary or before its data");

endmodule

//--- hdl/stream_buffer_top.sv
`timescale 1ns/1ps

`include "stream_buf_settings.svh"

module stream_buffer_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  stream_buf_pkg::sample_t sample_in,
    input  logic                    sample_valid,
    input  logic                    drain,
    output stream_buf_pkg::sample_t sample_out,
    output logic                    sample_out_valid,
    output logic                    overflow,
    output stream_buf_pkg::count_t  word_count
);
    import stream_buf_pkg::*;

    word_t   packed_word;
    wr_req_t wr;
    logic    rd_stall;
    addr_t   rd_addr;
    word_t   rd_data;
    logic    start_batch;

    // ----------------------------------------
    // control
    // ----------------------------------------
    batch_controller u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .sample_valid     (sample_valid),
        .drain            (drain),
        .packed_word      (packed_word),
        .wr               (wr),
        .rd_stall         (rd_stall),
        .rd_addr          (rd_addr),
        .start_batch      (start_batch),
        .sample_out_valid (sample_out_valid),
        .overflow         (overflow),
        .word_count       (word_count)
    );

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    packing_shift_register #(
        .WIDTH (`SAMPLE_BITS),
        .DEPTH (`PACK_DEPTH)
    ) u_pack (
        .clk        (clk),
        .shift_en   (sample_valid),
        .sample_in  (sample_in),
        .packed_out (packed_word)
    );

    memory_block #(
        .WIDTH      (`WORD_BITS),
        .DEPTH_LOG2 (`ADDR_BITS),
        .OUT_STAGES (`MEM_OUT_STAGES)
    ) u_mem (
        .clk      (clk),
        .wr       (wr),
        .rd_stall (rd_stall),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    unpacking_shift_register #(
        .WIDTH (`SAMPLE_BITS),
        .DEPTH (`PACK_DEPTH)
    ) u_unpack (
        .clk         (clk),
        .start_batch (start_batch),
        .packed_in   (rd_data),
        .sample_out  (sample_out)
    );

endmodule

//--- verification/stream_buffer_tb.sv
`timescale 1ns/1ps

`include "stream_buf_settings.svh"

module stream_buffer_tb;
    import stream_buf_pkg::*;

    localparam int DEPTH = `MEM_DEPTH;
    localparam int PACK  = `PACK_DEPTH;

    typedef struct packed {
        logic       valid;
        logic       drain;
        logic       exp_ovf;                // row completes a dropped word.
        logic       chk;                    // settled point, check counts.
        count_t     exp_count;
        logic [7:0] exp_run;                // 0 skips the run check.
    } row_t;

    logic    clk;
    logic    rst_n;
    sample_t sample_in;
    logic    sample_valid;
    logic    drain;
    sample_t sample_out;
    logic    sample_out_valid;
    logic    overflow;
    count_t  word_count;

    row_t    rows[$];
    sample_t expected[$];
    sample_t group[$];
    sample_t head;
    int      model_words;
    int      run_len;
    int      last_run;
    int      data_errors;
    int      ovf_errors;
    int      count_errors;
    int      other_errors;
    bit      table_ready;

    stream_buffer_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .sample_in        (sample_in),
        .sample_valid     (sample_valid),
        .drain            (drain),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .overflow         (overflow),
        .word_count       (word_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // stimulus table
    // ----------------------------------------
    task automatic add_row(input logic valid, input logic drain_lvl, input logic exp_ovf,
                           input logic chk, input int exp_run);
        row_t r;
        r.valid     = valid;
        r.drain     = drain_lvl;
        r.exp_ovf   = exp_ovf;
        r.chk       = chk;
        r.exp_count = count_t'(model_words);
        r.exp_run   = 8'(exp_run);
        rows.push_back(r);
    endtask

    // whole words only, so the packer stays aligned between phases.
    task automatic add_words(input int n, input logic drain_lvl);
        logic drop;
        for (int w = 0; w < n; w++) begin
            drop = 1'b0;
            if (!drain_lvl) begin
                if (model_words == DEPTH) begin
                    drop = 1'b1;            // memory full.
                end else begin
                    model_words++;
                end
            end
            for (int s = 0; s < PACK; s++) begin
                add_row(1'b1, drain_lvl, drop && (s == PACK - 1), 1'b0, 0);
            end
        end
    endtask

    task automatic add_idle(input int n, input logic drain_lvl, input logic chk_last,
                            input int exp_run);
        for (int i = 0; i < n; i++) begin
            add_row(1'b0, drain_lvl, 1'b0, chk_last && (i == n - 1),
                    (i == n - 1) ? exp_run : 0);
        end
    endtask

    task automatic drain_all(input int n, input int exp_run);
        model_words = 0;
        add_idle(n, 1'b1, 1'b1, exp_run);
    endtask

    task automatic build_table();
        add_idle(4, 1'b0, 1'b1, 0);
        // order, words held then read back in one gapless run
        add_words(3, 1'b0);
        add_idle(6, 1'b0, 1'b1, 0);
        drain_all(24, 3 * PACK);
        // continuous stream with drain high
        add_words(8, 1'b1);
        drain_all(24, 0);
        // fill to the top, then two words that must be dropped
        add_words(DEPTH + 2, 1'b0);
        add_idle(6, 1'b0, 1'b1, 0);
        drain_all(76, DEPTH * PACK);
        // drain released mid-stream and raised again
        add_words(4, 1'b0);
        add_idle(6, 1'b1, 1'b0, 0);
        add_idle(12, 1'b0, 1'b0, 0);
        drain_all(30, 0);
        // empty buffer stays quiet
        drain_all(12, 0);
    endtask

    // ----------------------------------------
    // drive and check
    // ----------------------------------------
    task automatic drive_row(input row_t r);
        sample_valid = r.valid;
        drain        = r.drain;
        sample_in    = sample_t'($urandom);
        if (r.valid) begin
            group.push_back(sample_in);
            if (group.size() == PACK) begin
                if (!r.exp_ovf) begin
                    foreach (group[k]) begin
                        expected.push_back(group[k]);
                    end
                end
                group.delete();
            end
        end
    endtask

    task automatic check_row(input row_t r);
        if (overflow !== r.exp_ovf) begin
            $display("FAIL overflow: got %h expected %h at %0t", overflow, r.exp_ovf, $time);
            ovf_errors++;
        end
        if (r.chk) begin
            if (word_count !== r.exp_count) begin
                $display("FAIL word_count: got %h expected %h at %0t",
                         word_count, r.exp_count, $time);
                count_errors++;
            end
            if (sample_out_valid !== 1'b0) begin
                $display("FAIL sample_out_valid: got %h expected 0 at %0t",
                         sample_out_valid, $time);
                other_errors++;
            end
            if (expected.size() != int'(r.exp_count) * PACK) begin
                $display("ERROR: %0d samples still awaited at %0t, expected %0d",
                         expected.size(), $time, int'(r.exp_count) * PACK);
                other_errors++;
            end
            if ((r.exp_run != 0) && (last_run != int'(r.exp_run))) begin
                $display("ERROR: last output run was %0d samples long, expected %0d",
                         last_run, r.exp_run);
                other_errors++;
            end
        end
    endtask

    task automatic print_counts();
        $display("errors: %0d total (data %0d, overflow %0d, count %0d, other %0d)",
                 data_errors + ovf_errors + count_errors + other_errors,
                 data_errors, ovf_errors, count_errors, other_errors);
    endtask

    // ----------------------------------------
    // scoreboard
    // ----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (sample_out_valid) begin
                run_len++;
                if (expected.size() == 0) begin
                    $display("ERROR: sample_out_valid high with no sample expected at %0t",
                             $time);
                    other_errors++;
                end else begin
                    head = expected.pop_front();
                    if (sample_out !== head) begin
                        $display("FAIL sample_out: got %h expected %h at %0t",
                                 sample_out, head, $time);
                        data_errors++;
                    end
                end
            end else if (run_len != 0) begin
                if (run_len % PACK != 0) begin
                    $display("ERROR: output stopped inside a word after %0d samples", run_len);
                    other_errors++;
                end
                last_run = run_len;
                run_len  = 0;
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        drain        = 1'b0;
        model_words  = 0;
        run_len      = 0;
        last_run     = 0;
        data_errors  = 0;
        ovf_errors   = 0;
        count_errors = 0;
        other_errors = 0;
        table_ready  = 1'b0;
        void'($urandom(32'h5928760a));
        build_table();
        table_ready = 1'b1;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(rows[i-1]);
            end
            drive_row(rows[i]);
        end
        @(negedge clk);
        check_row(rows[rows.size()-1]);
        sample_valid = 1'b0;
        repeat (4) @(negedge clk);
        if (expected.size() != 0) begin
            $display("ERROR: %0d samples never came out", expected.size());
            other_errors++;
        end

        print_counts();
        if (data_errors + ovf_errors + count_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (table_ready);
        #((rows.size() + 200) * 4);
        $display("ERROR: watchdog expired before the table finished");
        other_errors++;
        print_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/stream_buf_pkg.sv
hdl/memory_block.sv
hdl/packing_shift_register.sv
hdl/unpacking_shift_register.sv
hdl/batch_controller.sv
hdl/stream_buffer_top.sv
verification/stream_buffer_tb.sv
